/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

	////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////
	localparam int xlen   = 32;		// Datapath width
	localparam int reg_aw = 5;		// Register index width

	// ADDI x0, x0, 0
	localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		op_rtype = 7'b0110011,		// ADD SUB AND OR XOR SLT
		op_itype = 7'b0010011,		// ADDI
		op_lui   = 7'b0110111,
		op_load  = 7'b0000011,		// LW
		op_store = 7'b0100011		// SW
	} opcode_t;

	// ALU operations
	typedef enum logic [3:0] {
		alu_add   = 4'd0,
		alu_sub   = 4'd1,
		alu_and   = 4'd2,
		alu_or    = 4'd3,
		alu_xor   = 4'd4,
		alu_slt   = 4'd5,
		alu_passb = 4'd6		// LUI passes the immediate straight through
	} alu_op_t;

	// Writeback source
	typedef enum logic [1:0] {
		wb_alu  = 2'd0,
		wb_load = 2'd1
	} wb_sel_t;

	// Forward selects for execute operands
	localparam logic [1:0] fwd_none = 2'd0;
	localparam logic [1:0] fwd_mem  = 2'd1;		// From exe_mem ALU result
	localparam logic [1:0] fwd_wb   = 2'd2;		// From mem_wb writeback data

endpackage

`default_nettype wire

/* verilog/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit import core_pkg::*; (
	input  wire logic [xlen-1:0] inst,
	output alu_op_t              alu_op,
	output logic                 use_imm,	// Operand B from immediate
	output logic                 reg_write,
	output logic                 mem_write,
	output logic                 mem_read,
	output wb_sel_t              wb_sel,
	output logic [xlen-1:0]      imm
);

	opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = opcode_t'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// Unknown encodings fall out as NOP
	always_comb begin
		alu_op    = alu_add;
		use_imm   = 1'b0;
		reg_write = 1'b0;
		mem_write = 1'b0;
		mem_read  = 1'b0;
		wb_sel    = wb_alu;
		imm       = {{(xlen-12){inst[31]}}, inst[31:20]};		// I-type by default
		case (opcode)
			op_rtype: begin
				reg_write = 1'b1;
				case (funct3)
					3'b000: alu_op = (funct7 == 7'b0100000) ? alu_sub : alu_add;
					3'b111: alu_op = alu_and;
					3'b110: alu_op = alu_or;
					3'b100: alu_op = alu_xor;
					3'b010: alu_op = alu_slt;
					default: reg_write = 1'b0;		// Not in subset
				endcase
			end
			op_itype: begin
				use_imm   = 1'b1;
				reg_write = (funct3 == 3'b000);		// ADDI only
			end
			op_lui: begin
				alu_op    = alu_passb;
				use_imm   = 1'b1;
				reg_write = 1'b1;
				imm       = {inst[31:12], 12'b0};
			end
			op_load: begin
				use_imm   = 1'b1;		// Address = rs1 + imm
				reg_write = 1'b1;
				mem_read  = 1'b1;
				wb_sel    = wb_load;
			end
			op_store: begin
				use_imm   = 1'b1;
				mem_write = 1'b1;
				imm       = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};	// S-type split
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile import core_pkg::*; (
	input  wire logic              CLK,
	input  wire logic              rst,
	input  wire logic              wr_en,
	input  wire logic [reg_aw-1:0] wr_addr,
	input  wire logic [xlen-1:0]   wr_data,
	input  wire logic [reg_aw-1:0] rd_addr_a,
	input  wire logic [reg_aw-1:0] rd_addr_b,
	output logic [xlen-1:0]        rd_data_a,
	output logic [xlen-1:0]        rd_data_b
);

	logic [xlen-1:0] regs [32];
	logic wr_live;		// Write that actually lands

	assign wr_live = wr_en && (wr_addr != '0);

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_live) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Same-cycle write shows up on read
	assign rd_data_a = (wr_live && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
	assign rd_data_b = (wr_live && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import core_pkg::*; (
	input  wire logic [xlen-1:0] op_a,
	input  wire logic [xlen-1:0] op_b,
	input  alu_op_t              alu_op,
	output logic [xlen-1:0]      res
);

	logic lt;		// Signed compare

	assign lt = $signed(op_a) < $signed(op_b);

	always_comb begin
		case (alu_op)
			alu_add:   res = op_a + op_b;
			alu_sub:   res = op_a - op_b;
			alu_and:   res = op_a & op_b;
			alu_or:    res = op_a | op_b;
			alu_xor:   res = op_a ^ op_b;
			alu_slt:   res = {{(xlen-1){1'b0}}, lt};
			alu_passb: res = op_b;		// LUI
			default:   res = '0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/forwarding_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit import core_pkg::*; (
	input  wire logic [reg_aw-1:0] id_rs_a,
	input  wire logic [reg_aw-1:0] id_rs_b,
	input  wire logic [reg_aw-1:0] exe_rs_a,
	input  wire logic [reg_aw-1:0] exe_rs_b,
	input  wire logic [reg_aw-1:0] exe_rd,
	input  wire logic [reg_aw-1:0] mem_rd,
	input  wire logic [reg_aw-1:0] wb_rd,
	input  wire logic              exe_mem_read,
	input  wire logic              mem_reg_write,
	input  wire logic              wb_reg_write,
	output logic [1:0]             fwd_a,
	output logic [1:0]             fwd_b,
	output logic                   load_stall
);

	logic mem_live;		// Producer in memory stage
	logic wb_live;		// Producer in writeback stage

	assign mem_live = mem_reg_write && (mem_rd != '0);
	assign wb_live  = wb_reg_write && (wb_rd != '0);

	// Newer stage wins
	function automatic logic [1:0] pick(input logic [reg_aw-1:0] rs);
		logic [1:0] sel;
		sel = fwd_none;
		if (mem_live && mem_rd == rs)
			sel = fwd_mem;
		else if (wb_live && wb_rd == rs)
			sel = fwd_wb;
		return sel;
	endfunction

	assign fwd_a = pick(exe_rs_a);
	assign fwd_b = pick(exe_rs_b);

	// Load data for decode only exists once the load reaches writeback
	assign load_stall = exe_mem_read && (exe_rd != '0) &&
		(exe_rd == id_rs_a || exe_rd == id_rs_b);

endmodule

`default_nettype wire

/* verilog/datamem.sv */
`timescale 1ns/1ps
`default_nettype none

module datamem import core_pkg::*; #(
	parameter int dmem_words = 1024
) (
	input  wire logic                          CLK,
	input  wire logic                          dm_write,
	input  wire logic [$clog2(dmem_words)-1:0] data_addr,
	input  wire logic [xlen-1:0]               data_in,
	input  wire logic [xlen/8-1:0]             con_write,	// Byte lanes
	input  wire logic [$clog2(dmem_words)-1:0] con_addr,
	input  wire logic [xlen-1:0]               con_in,
	output logic [xlen-1:0]                    data_out,
	output logic [xlen-1:0]                    con_out
);

	logic [xlen-1:0] mem [dmem_words];

	always_ff @(posedge CLK) begin
		for (int i = 0; i < xlen/8; i++) begin
			if (con_write[i])
				mem[con_addr][8*i +: 8] <= con_in[8*i +: 8];
		end
		if (dm_write)
			mem[data_addr] <= data_in;	// Last assignment so core wins on collision
	end

	// Both ports read combinationally
	assign data_out = mem[data_addr];
	assign con_out  = mem[con_addr];

endmodule

`default_nettype wire

/* verilog/core.sv */
`timescale 1ns/1ps
`default_nettype none

module core import core_pkg::*; #(
	parameter int imem_words = 256,
	parameter int dmem_words = 1024
) (
	input  wire logic                          CLK,
	input  wire logic                          rst,
	input  wire logic [xlen/8-1:0]             con_write,
	input  wire logic [$clog2(dmem_words)-1:0] con_addr,
	input  wire logic [xlen-1:0]               con_in,
	output logic [xlen-1:0]                    con_out		// Controller side of data memory
);

	localparam int im_aw = $clog2(imem_words);
	localparam int dm_aw = $clog2(dmem_words);

	////////////////////////////////////////////////
	// Fetch
	////////////////////////////////////////////////
	logic [xlen-1:0] pc;
	logic [xlen-1:0] if_inst;
	logic [xlen-1:0] imem [imem_words];
	logic load_stall;

	initial begin
		for (int i = 0; i < imem_words; i++)
			imem[i] = nop_inst;		// Unused slots run as NOP
		$readmemh("program.hex", imem);
	end

	assign if_inst = imem[pc[im_aw+1:2]];

	always_ff @(posedge CLK) begin
		if (rst)
			pc <= '0;
		else if (!load_stall)
			pc <= pc + 4;		// No branches
	end

	////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////
	logic [xlen-1:0] id_inst;
	logic id_valid;
	logic [reg_aw-1:0] id_rs_a, id_rs_b, id_rd;
	logic [xlen-1:0] id_rf_a, id_rf_b, id_imm;
	alu_op_t id_alu_op;
	wb_sel_t id_wb_sel;
	logic id_use_imm, id_reg_write, id_mem_write, id_mem_read;
	logic [reg_aw-1:0] wb_rd;
	logic [xlen-1:0] wb_data;
	logic wb_reg_write;

	always_ff @(posedge CLK) begin
		if (rst)
			id_valid <= 1'b0;
		else if (!load_stall)
			id_valid <= 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (!load_stall)
			id_inst <= if_inst;		// Held during stall
	end

	assign id_rs_a = id_inst[19:15];
	assign id_rs_b = id_inst[24:20];
	assign id_rd   = id_inst[11:7];

	control_unit control_unit_inst (
		.inst(id_inst),
		.alu_op(id_alu_op),
		.use_imm(id_use_imm),
		.reg_write(id_reg_write),
		.mem_write(id_mem_write),
		.mem_read(id_mem_read),
		.wb_sel(id_wb_sel),
		.imm(id_imm)
	);

	regfile regfile_inst (
		.CLK(CLK),
		.rst(rst),
		.wr_en(wb_reg_write),
		.wr_addr(wb_rd),
		.wr_data(wb_data),
		.rd_addr_a(id_rs_a),
		.rd_addr_b(id_rs_b),
		.rd_data_a(id_rf_a),
		.rd_data_b(id_rf_b)
	);

	////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////
	logic [xlen-1:0] exe_rf_a, exe_rf_b, exe_imm;
	logic [reg_aw-1:0] exe_rs_a, exe_rs_b, exe_rd;
	alu_op_t exe_alu_op;
	wb_sel_t exe_wb_sel;
	logic exe_use_imm, exe_reg_write, exe_mem_write, exe_mem_read;
	logic [1:0] fwd_a, fwd_b;
	logic [xlen-1:0] exe_op_a, exe_fwd_b, exe_op_b, exe_alu_out;
	logic [reg_aw-1:0] mem_rd;
	logic [xlen-1:0] mem_alu_out;
	logic mem_reg_write;

	// Control side takes a bubble on stall or empty decode
	always_ff @(posedge CLK) begin
		if (rst || load_stall || !id_valid) begin
			exe_reg_write <= 1'b0;
			exe_mem_write <= 1'b0;
			exe_mem_read  <= 1'b0;
			exe_use_imm   <= 1'b0;
			exe_alu_op    <= alu_add;
			exe_wb_sel    <= wb_alu;
		end else begin
			exe_reg_write <= id_reg_write && (id_rd != '0);		// x0 never written
			exe_mem_write <= id_mem_write;
			exe_mem_read  <= id_mem_read;
			exe_use_imm   <= id_use_imm;
			exe_alu_op    <= id_alu_op;
			exe_wb_sel    <= id_wb_sel;
		end
	end

	always_ff @(posedge CLK) begin
		exe_rf_a <= id_rf_a;
		exe_rf_b <= id_rf_b;
		exe_imm  <= id_imm;
		exe_rs_a <= id_rs_a;
		exe_rs_b <= id_rs_b;
		exe_rd   <= id_rd;
	end

	forwarding_unit forwarding_unit_inst (
		.id_rs_a(id_rs_a),
		.id_rs_b(id_rs_b),
		.exe_rs_a(exe_rs_a),
		.exe_rs_b(exe_rs_b),
		.exe_rd(exe_rd),
		.mem_rd(mem_rd),
		.wb_rd(wb_rd),
		.exe_mem_read(exe_mem_read),
		.mem_reg_write(mem_reg_write),
		.wb_reg_write(wb_reg_write),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.load_stall(load_stall)
	);

	assign exe_op_a  = (fwd_a == fwd_mem) ? mem_alu_out :
		(fwd_a == fwd_wb) ? wb_data : exe_rf_a;
	assign exe_fwd_b = (fwd_b == fwd_mem) ? mem_alu_out :
		(fwd_b == fwd_wb) ? wb_data : exe_rf_b;		// Also the store data
	assign exe_op_b  = exe_use_imm ? exe_imm : exe_fwd_b;

	alu alu_inst (
		.op_a(exe_op_a),
		.op_b(exe_op_b),
		.alu_op(exe_alu_op),
		.res(exe_alu_out)
	);

	////////////////////////////////////////////////
	// Memory
	////////////////////////////////////////////////
	logic [xlen-1:0] mem_store_data, mem_load_data;
	logic mem_dm_write;
	wb_sel_t mem_wb_sel;

	always_ff @(posedge CLK) begin
		if (rst) begin
			mem_reg_write <= 1'b0;
			mem_dm_write  <= 1'b0;
			mem_wb_sel    <= wb_alu;
		end else begin
			mem_reg_write <= exe_reg_write;
			mem_dm_write  <= exe_mem_write;
			mem_wb_sel    <= exe_wb_sel;
		end
	end

	always_ff @(posedge CLK) begin
		mem_alu_out    <= exe_alu_out;
		mem_store_data <= exe_fwd_b;
		mem_rd         <= exe_rd;
	end

	datamem #(
		.dmem_words(dmem_words)
	) datamem_inst (
		.CLK(CLK),
		.dm_write(mem_dm_write),
		.data_addr(mem_alu_out[dm_aw+1:2]),		// Byte address to word index
		.data_in(mem_store_data),
		.con_write(con_write),
		.con_addr(con_addr),
		.con_in(con_in),
		.data_out(mem_load_data),
		.con_out(con_out)
	);

	////////////////////////////////////////////////
	// Writeback
	////////////////////////////////////////////////
	logic [xlen-1:0] wb_alu_out, wb_load_data;
	wb_sel_t wb_src;

	always_ff @(posedge CLK) begin
		if (rst) begin
			wb_reg_write <= 1'b0;
			wb_src       <= wb_alu;
		end else begin
			wb_reg_write <= mem_reg_write;
			wb_src       <= mem_wb_sel;
		end
	end

	always_ff @(posedge CLK) begin
		wb_alu_out   <= mem_alu_out;
		wb_load_data <= mem_load_data;
		wb_rd        <= mem_rd;
	end

	assign wb_data = (wb_src == wb_load) ? wb_load_data : wb_alu_out;

endmodule

`default_nettype wire

/* tb/core_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module core_assertions import core_pkg::*; (
	input wire logic              CLK,
	input wire logic              rst,
	input wire logic              load_stall,
	input wire logic              exe_reg_write,
	input wire logic              exe_mem_write,
	input wire logic              mem_reg_write,
	input wire logic              mem_dm_write,
	input wire logic              wb_reg_write,
	input wire logic [reg_aw-1:0] wb_rd		// Regfile write index
);

	logic any_write;		// Any enable along the pipe

	assign any_write = exe_reg_write || exe_mem_write || mem_reg_write ||
		mem_dm_write || wb_reg_write;

	// Regfile port never aimed at x0
	x0_write: assert property (@(posedge CLK) disable iff (rst)
		wb_reg_write |-> (wb_rd != '0))
		else $error("register write aimed at x0");

	// One bubble per load-use pair
	single_stall: assert property (@(posedge CLK) disable iff (rst)
		load_stall |=> !load_stall)
		else $error("load_stall held for two consecutive cycles");

	// Held reset plus the first cycle after release
	quiet_reset: assert property (@(posedge CLK)
		($past(rst) || $past(rst, 2)) |-> !any_write)
		else $error("write enable active during or right after reset");

endmodule

bind core core_assertions core_assertions_inst (
	.CLK(CLK),
	.rst(rst),
	.load_stall(load_stall),
	.exe_reg_write(exe_reg_write),
	.exe_mem_write(exe_mem_write),
	.mem_reg_write(mem_reg_write),
	.mem_dm_write(mem_dm_write),
	.wb_reg_write(wb_reg_write),
	.wb_rd(wb_rd)
);

`default_nettype wire

/* tb/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb import core_pkg::*; ();

	localparam int dmem_words    = 1024;
	localparam int dm_aw         = $clog2(dmem_words);
	localparam int clk_period    = 4;		// ns
	localparam int reset_cycles  = 10;
	localparam int seed_cycles   = 10;		// Con port preload
	localparam int run_cycles    = 60;
	localparam int read_cycles   = 20;
	localparam int margin_cycles = 50;
	localparam int timeout_ns    = (reset_cycles + seed_cycles + run_cycles +
		read_cycles + margin_cycles) * clk_period;

	logic CLK;
	logic rst;
	logic [xlen/8-1:0] con_write;
	logic [dm_aw-1:0] con_addr;
	logic [xlen-1:0] con_in;
	logic [xlen-1:0] con_out;

	logic [31:0] lfsr;
	logic [xlen-1:0] ops [4];		// Data words 0..3
	logic [xlen-1:0] word8;			// Expected, built lane by lane
	int checks;
	int errors;

	core #(
		.imem_words(256),
		.dmem_words(dmem_words)
	) core_inst (
		.CLK(CLK),
		.rst(rst),
		.con_write(con_write),
		.con_addr(con_addr),
		.con_in(con_in),
		.con_out(con_out)
	);

	initial begin
		CLK = 1'b0;
		forever #(clk_period / 2) CLK = ~CLK;
	end

	initial begin
		rst <= 1'b1;
		repeat (reset_cycles) @(posedge CLK);
		rst <= 1'b0;
	end

	// Watchdog
	initial begin
		#(timeout_ns);
		$display("Timeout after %0d ns, results never read back", timeout_ns);
		$display("Testbench failed");
		$finish;
	end

	////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////

	// Galois form of x^32 + x^31 + x^29 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	// RISC-V SLT from the sign bits and an unsigned compare
	function automatic logic [xlen-1:0] signed_less(input logic [xlen-1:0] a,
		input logic [xlen-1:0] b);
		logic lt;
		if (a[xlen-1] != b[xlen-1])
			lt = a[xlen-1];		// Negative side is smaller
		else
			lt = (a < b);
		return {{(xlen-1){1'b0}}, lt};
	endfunction

	task automatic random_word(output logic [xlen-1:0] w);
		int i;
		for (i = 0; i < xlen; i++) begin
			w[i] = lfsr[0];		// One step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic write_lanes(input int addr, input logic [xlen-1:0] data,
		input logic [xlen/8-1:0] lanes);
		@(posedge CLK);
		con_write <= lanes;
		con_addr  <= dm_aw'(addr);
		con_in    <= data;
	endtask

	// Combinational read sampled mid-cycle
	task automatic read_word(input int addr, output logic [xlen-1:0] data);
		@(posedge CLK);
		con_write <= '0;
		con_addr  <= dm_aw'(addr);
		@(negedge CLK);
		data = con_out;
	endtask

	task automatic check_word(input string name, input int addr, input logic [xlen-1:0] exp);
		logic [xlen-1:0] got;
		read_word(addr, got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch con_out word %0d (%s): expected %h, actual %h",
				addr, name, exp, got);
		end
	endtask

	////////////////////////////////////////////////
	// Stimulus and checks
	////////////////////////////////////////////////
	initial begin
		logic [xlen-1:0] w;
		logic [xlen/8-1:0] strobe;
		int i;
		con_write <= '0;
		con_addr  <= '0;
		con_in    <= '0;
		lfsr   = 32'd31593;
		checks = 0;
		errors = 0;
		word8  = '0;

		for (i = 0; i < 4; i++)
			random_word(ops[i]);
		ops[0][xlen-1] = 1'b1;		// Negative against positive so SLT differs from SLTU
		ops[1][xlen-1] = 1'b0;

		// Preload while the core sits in reset
		for (i = 0; i < 4; i++)
			write_lanes(i, ops[i], '1);
		for (i = 0; i < xlen / 8; i++) begin
			random_word(w);		// Other lanes carry junk
			word8[8*i +: 8] = w[8*i +: 8];
			strobe = '0;
			strobe[i] = 1'b1;
			write_lanes(8, w, strobe);
		end
		@(posedge CLK);
		con_write <= '0;

		wait (rst == 1'b0);
		repeat (run_cycles) @(posedge CLK);

		for (i = 0; i < 4; i++)
			check_word($sformatf("operand %0d", i), i, ops[i]);
		check_word("lane strobes", 8, word8);
		check_word("add", 16, ops[0] + ops[1]);
		check_word("sub", 17, ops[0] - ops[1]);
		check_word("and", 18, ops[0] & ops[1]);
		check_word("or", 19, ops[0] | ops[1]);
		check_word("xor", 20, ops[0] ^ ops[1]);
		check_word("slt", 21, signed_less(ops[0], ops[1]));
		check_word("addi", 22, ops[2] + 32'h0000_0123);		// Positive immediate
		check_word("lui", 23, 32'hABCD_E000);
		check_word("forwarded add", 24, 32'hABCD_E000 + ops[2] + 32'h0000_0123);
		check_word("load-use add", 25, ops[3] + ops[0]);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* program.hex */
// One instruction word per line, in hex, from address 0
// Operands in data words 0..3, results go to words 16..25
00002083	// lw   x1, 0(x0)
00402103	// lw   x2, 4(x0)
00802183	// lw   x3, 8(x0)
002082B3	// add  x5, x1, x2
40208333	// sub  x6, x1, x2
0020F3B3	// and  x7, x1, x2
0020E433	// or   x8, x1, x2
0020C4B3	// xor  x9, x1, x2
0020A533	// slt  x10, x1, x2
12318593	// addi x11, x3, 0x123
ABCDE637	// lui  x12, 0xABCDE
00B606B3	// add  x13, x12, x11   x12 from memory stage, x11 from writeback
00C02203	// lw   x4, 12(x0)
00120733	// add  x14, x4, x1     load-use, one stall
04502023	// sw   x5, 64(x0)
04602223	// sw   x6, 68(x0)
04702423	// sw   x7, 72(x0)
04802623	// sw   x8, 76(x0)
04902823	// sw   x9, 80(x0)
04A02A23	// sw   x10, 84(x0)
04B02C23	// sw   x11, 88(x0)
04C02E23	// sw   x12, 92(x0)
06D02023	// sw   x13, 96(x0)
06E02223	// sw   x14, 100(x0)

/* project.f */
verilog/core_pkg.sv
verilog/control_unit.sv
verilog/regfile.sv
verilog/alu.sv
verilog/forwarding_unit.sv
verilog/datamem.sv
verilog/core.sv
tb/core_assertions.sv
tb/core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_tb -f project.f -o core_tb_sim \
	&& ./obj_dir/core_tb_sim | tee /dev/stderr | grep -x "Testbench passed" > /dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
